// File: common/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // bus widths.
  localparam int ADDR_SIZE  = 32;
  localparam int DATA_SIZE  = 32;
  localparam int BYTE_SIZE  = 8;
  localparam int BLOCK_SIZE = 128;

  // field widths of an address.
  localparam int BYTE_NUM         = DATA_SIZE / BYTE_SIZE;
  localparam int OFFSET_BITS      = $clog2(BLOCK_SIZE / BYTE_SIZE);
  localparam int DATA_OFFSET_BITS = $clog2(BYTE_NUM);

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_t;

  typedef struct packed {
    logic                 write;
    size_t                size;
    logic                 rd_signed;   // sign-extend loads.
    logic [ADDR_SIZE-1:0] addr;
    logic [DATA_SIZE-1:0] wr_data;     // store data, right aligned.
  } cpu_req_t;

  typedef struct packed {
    logic                  write;
    logic [ADDR_SIZE-1:0]  addr;       // always line aligned.
    logic [BLOCK_SIZE-1:0] wr_data;
  } mem_req_t;

endpackage

`default_nettype wire

// File: source/left_barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module left_barrel_shifter #(
  parameter int LANES     = 4,
  parameter int LANE_BITS = 8
) (
  input  logic [LANES*LANE_BITS-1:0] in_data,
  input  logic [$clog2(LANES)-1:0]   shamt,
  output logic [LANES*LANE_BITS-1:0] out_data
);

  localparam int STAGES = $clog2(LANES);
  localparam int WIDTH  = LANES * LANE_BITS;

  logic [STAGES:0][WIDTH-1:0] stage;

  assign stage[0] = in_data;

  // each stage moves by a power of two lanes, zeros come in from the right.
  for (genvar i = 0; i < STAGES; i++) begin : gen_stage
    assign stage[i+1] = shamt[i] ? stage[i] << (LANE_BITS * (2 ** i)) : stage[i];
  end

  assign out_data = stage[STAGES];

endmodule

`default_nettype wire

// File: source/right_barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module right_barrel_shifter (
  input  logic [cache_pkg::DATA_SIZE-1:0]        in_data,
  input  logic [cache_pkg::DATA_OFFSET_BITS-1:0] shamt,
  input  logic                                   arithmetic,
  output logic [cache_pkg::DATA_SIZE-1:0]        out_data
);

  import cache_pkg::*;

  localparam int STAGES = DATA_OFFSET_BITS;

  logic                           fill;
  logic [STAGES:0][DATA_SIZE-1:0] stage;

  assign fill     = arithmetic & in_data[DATA_SIZE-1];  // sign or zero.
  assign stage[0] = in_data;

  // log2 stages of whole-byte moves.
  for (genvar i = 0; i < STAGES; i++) begin : gen_stage
    localparam int SHIFT_BITS = BYTE_SIZE * (2 ** i);

    assign stage[i+1] = shamt[i] ?
                        {{SHIFT_BITS{fill}}, stage[i][DATA_SIZE-1:SHIFT_BITS]} :
                        stage[i];
  end

  assign out_data = stage[STAGES];

endmodule

`default_nettype wire

// File: cache/cache_path.sv
`timescale 1ns/1ps
`default_nettype none

module cache_path #(
  parameter int CACHE_LINES = 256
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             sample,
  input  cache_pkg::cpu_req_t              cpu_req,
  input  logic                             set_valid,
  input  logic                             set_tag,
  input  logic                             set_data,
  input  logic                             set_dirty,
  input  logic                             mem_addr_src,
  input  logic [cache_pkg::BLOCK_SIZE-1:0] mem_rd_data,
  output logic [cache_pkg::DATA_SIZE-1:0]  cpu_rd_data,
  output logic [cache_pkg::ADDR_SIZE-1:0]  mem_addr,
  output logic [cache_pkg::BLOCK_SIZE-1:0] mem_wr_data,
  output logic                             req_write,
  output logic                             hit,
  output logic                             dirty
);

  import cache_pkg::*;

  localparam int INDEX_BITS = $clog2(CACHE_LINES);
  localparam int WORD_BITS  = OFFSET_BITS - DATA_OFFSET_BITS;
  localparam int TAG_BITS   = ADDR_SIZE - INDEX_BITS - OFFSET_BITS;

  cpu_req_t                    req_q;
  logic [TAG_BITS-1:0]         tag;
  logic [INDEX_BITS-1:0]       index;
  logic [WORD_BITS-1:0]        word_sel;
  logic [DATA_OFFSET_BITS-1:0] byte_off;

  logic [CACHE_LINES-1:0] valid_q;
  logic [CACHE_LINES-1:0] dirty_q;
  logic [TAG_BITS-1:0]    tag_q [CACHE_LINES];
  logic [BLOCK_SIZE-1:0]  data_q [CACHE_LINES];

  logic [BLOCK_SIZE-1:0] line_rd;
  logic [BLOCK_SIZE-1:0] merged_line;
  logic [DATA_SIZE-1:0]  word_rd;
  logic [DATA_SIZE-1:0]  wr_shifted;
  logic [DATA_SIZE-1:0]  rd_shifted;
  logic [BYTE_NUM-1:0]   sel;
  logic [BYTE_NUM-1:0]   sel_shifted;
  logic                  sign_bit;
  logic                  ext_bit;

  // request is held for the whole transaction.
  always_ff @(posedge clock) begin
    if (sample) req_q <= cpu_req;
  end

  assign tag       = req_q.addr[ADDR_SIZE-1 -: TAG_BITS];
  assign index     = req_q.addr[OFFSET_BITS +: INDEX_BITS];
  assign word_sel  = req_q.addr[DATA_OFFSET_BITS +: WORD_BITS];
  assign byte_off  = req_q.addr[0 +: DATA_OFFSET_BITS];
  assign req_write = req_q.write;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (set_valid) valid_q[index] <= 1'b1;
      if (set_data) dirty_q[index] <= set_dirty;  // refill leaves the line clean.
    end
  end

  always_ff @(posedge clock) begin
    if (set_tag) tag_q[index] <= tag;
    if (set_data) data_q[index] <= set_dirty ? merged_line : mem_rd_data;
  end

  assign line_rd = data_q[index];
  assign word_rd = line_rd[word_sel*DATA_SIZE +: DATA_SIZE];

  // byte enables and the sign position of the access size.
  always_comb begin
    case (req_q.size)
      size_byte: begin
        sel      = BYTE_NUM'(1);
        sign_bit = rd_shifted[BYTE_SIZE-1];
      end
      size_half: begin
        sel      = BYTE_NUM'(3);
        sign_bit = rd_shifted[2*BYTE_SIZE-1];
      end
      default: begin
        sel      = '1;
        sign_bit = rd_shifted[DATA_SIZE-1];
      end
    endcase
  end

  left_barrel_shifter #(.LANES(BYTE_NUM), .LANE_BITS(BYTE_SIZE)) wr_shifter (
    .in_data  (req_q.wr_data),
    .shamt    (byte_off),
    .out_data (wr_shifted)
  );

  left_barrel_shifter #(.LANES(BYTE_NUM), .LANE_BITS(1)) sel_shifter (
    .in_data  (sel),
    .shamt    (byte_off),
    .out_data (sel_shifted)
  );

  // store merge into the addressed word.
  always_comb begin
    merged_line = line_rd;
    for (int b = 0; b < BYTE_NUM; b++) begin
      if (sel_shifted[b]) begin
        merged_line[word_sel*DATA_SIZE + b*BYTE_SIZE +: BYTE_SIZE] =
          wr_shifted[b*BYTE_SIZE +: BYTE_SIZE];
      end
    end
  end

  right_barrel_shifter rd_shifter (
    .in_data    (word_rd),
    .shamt      (byte_off),
    .arithmetic (req_q.rd_signed),
    .out_data   (rd_shifted)
  );

  assign ext_bit = sign_bit & req_q.rd_signed;

  // unselected bytes take the extension.
  always_comb begin
    for (int b = 0; b < BYTE_NUM; b++) begin
      cpu_rd_data[b*BYTE_SIZE +: BYTE_SIZE] = sel[b] ?
                                              rd_shifted[b*BYTE_SIZE +: BYTE_SIZE] :
                                              {BYTE_SIZE{ext_bit}};
    end
  end

  // victim line on write-back, requested line otherwise.
  assign mem_addr = mem_addr_src ?
                    {tag_q[index], index, {OFFSET_BITS{1'b0}}} :
                    {req_q.addr[ADDR_SIZE-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  assign mem_wr_data = line_rd;

  assign hit   = valid_q[index] && (tag_q[index] == tag);
  assign dirty = dirty_q[index];

endmodule

`default_nettype wire

// File: cache/cache_control.sv
`timescale 1ns/1ps
`default_nettype none

module cache_control (
  input  logic clock,
  input  logic reset,
  input  logic cpu_req_valid,
  input  logic req_write,
  input  logic hit,
  input  logic dirty,
  input  logic mem_ack,
  output logic sample,
  output logic set_valid,
  output logic set_tag,
  output logic set_data,
  output logic set_dirty,
  output logic mem_addr_src,
  output logic mem_req_valid,
  output logic mem_write,
  output logic cpu_done
);

  typedef enum logic [1:0] {
    idle       = 2'd0,
    compare    = 2'd1,
    write_back = 2'd2,
    refill     = 2'd3
  } state_t;

  state_t state;
  state_t state_next;

  logic in_compare;
  logic miss;
  logic victim_dirty;
  logic refill_done;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        if (cpu_req_valid) state_next = compare;
      end
      compare: begin
        if (hit) begin
          state_next = idle;
        end else if (dirty) begin
          state_next = write_back;  // victim goes out first.
        end else begin
          state_next = refill;
        end
      end
      write_back: begin
        if (mem_ack) state_next = refill;
      end
      refill: begin
        if (mem_ack) state_next = compare;  // retry lookup, hits now.
      end
      default: state_next = idle;
    endcase
  end

  assign in_compare   = (state == compare);
  assign miss         = in_compare & ~hit;
  assign victim_dirty = miss & dirty;
  assign refill_done  = (state == refill) & mem_ack;

  assign sample   = (state == idle) & cpu_req_valid;
  assign cpu_done = in_compare & hit;

  // one strobe on entry to write_back or refill.
  assign mem_req_valid = miss | ((state == write_back) & mem_ack);
  assign mem_write     = victim_dirty;
  assign mem_addr_src  = victim_dirty;

  // refill installs the line; a store hit writes and marks it dirty.
  assign set_valid = refill_done;
  assign set_tag   = refill_done;
  assign set_dirty = cpu_done & req_write;
  assign set_data  = set_dirty | refill_done;

endmodule

`default_nettype wire

// File: source/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem #(
  parameter int CACHE_LINES = 256
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             cpu_req_valid,
  input  cache_pkg::cpu_req_t              cpu_req,
  output logic                             cpu_done,
  output logic [cache_pkg::DATA_SIZE-1:0]  cpu_rd_data,
  output logic                             mem_req_valid,
  output cache_pkg::mem_req_t              mem_req,
  input  logic                             mem_ack,
  input  logic [cache_pkg::BLOCK_SIZE-1:0] mem_rd_data
);

  import cache_pkg::*;

  logic sample;
  logic set_valid;
  logic set_tag;
  logic set_data;
  logic set_dirty;
  logic mem_addr_src;
  logic mem_write;
  logic req_write;
  logic hit;
  logic dirty;

  logic [ADDR_SIZE-1:0]  mem_addr;
  logic [BLOCK_SIZE-1:0] mem_wr_data;

  cache_control u_control (
    .clock         (clock),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .req_write     (req_write),
    .hit           (hit),
    .dirty         (dirty),
    .mem_ack       (mem_ack),
    .sample        (sample),
    .set_valid     (set_valid),
    .set_tag       (set_tag),
    .set_data      (set_data),
    .set_dirty     (set_dirty),
    .mem_addr_src  (mem_addr_src),
    .mem_req_valid (mem_req_valid),
    .mem_write     (mem_write),
    .cpu_done      (cpu_done)
  );

  cache_path #(.CACHE_LINES(CACHE_LINES)) u_path (
    .clock        (clock),
    .reset        (reset),
    .sample       (sample),
    .cpu_req      (cpu_req),
    .set_valid    (set_valid),
    .set_tag      (set_tag),
    .set_data     (set_data),
    .set_dirty    (set_dirty),
    .mem_addr_src (mem_addr_src),
    .mem_rd_data  (mem_rd_data),
    .cpu_rd_data  (cpu_rd_data),
    .mem_addr     (mem_addr),
    .mem_wr_data  (mem_wr_data),
    .req_write    (req_write),
    .hit          (hit),
    .dirty        (dirty)
  );

  assign mem_req.write   = mem_write;
  assign mem_req.addr    = mem_addr;
  assign mem_req.wr_data = mem_wr_data;

endmodule

`default_nettype wire

// File: test/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  import cache_pkg::*;

  localparam int CACHE_LINES     = 16;
  localparam int CLOCK_PERIOD    = 8;
  localparam int RESET_CYCLES    = 4;
  localparam int MEM_BYTES       = 4096;
  localparam int LINE_BYTES      = BLOCK_SIZE / BYTE_SIZE;
  localparam int RANDOM_OPS      = 200;
  localparam int REQUEST_TIMEOUT = 40;
  // cold load, offsets, hit timing, write-back, random plus sweep.
  localparam int REQUEST_COUNT   = 1 + 34 + 1 + 2 + RANDOM_OPS + CACHE_LINES;

  logic                  clock;
  logic                  reset;
  logic                  cpu_req_valid;
  cpu_req_t              cpu_req;
  logic                  cpu_done;
  logic [DATA_SIZE-1:0]  cpu_rd_data;
  logic                  mem_req_valid;
  mem_req_t              mem_req;
  logic                  mem_ack;
  logic [BLOCK_SIZE-1:0] mem_rd_data;

  logic [7:0] mem_bytes [MEM_BYTES];  // memory model contents.
  logic [7:0] shadow [MEM_BYTES];     // architectural view.
  mem_req_t   strobes [$];            // every memory request seen.
  int         value_errors = 0;
  int         other_errors = 0;
  int         done_cycles;

  cache_subsystem #(.CACHE_LINES(CACHE_LINES)) uut (
    .clock         (clock),
    .reset         (reset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req       (cpu_req),
    .cpu_done      (cpu_done),
    .cpu_rd_data   (cpu_rd_data),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_ack       (mem_ack),
    .mem_rd_data   (mem_rd_data)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 4) ^ 8'h3c;
  endfunction

  // sized bytes from the shadow, then sign or zero extension.
  function automatic logic [31:0] expected_load(input logic [31:0] addr, input size_t size,
                                                input logic is_signed);
    int          n;
    logic [31:0] value;
    n = 1 << size;
    value = '0;
    for (int i = 0; i < n; i++) value[8*i +: 8] = shadow[addr[11:0] + i];
    if (is_signed && value[8*n-1]) begin
      for (int i = n; i < 4; i++) value[8*i +: 8] = 8'hff;
    end
    return value;
  endfunction

  function automatic logic [BLOCK_SIZE-1:0] shadow_line(input logic [31:0] addr);
    logic [BLOCK_SIZE-1:0] line;
    for (int k = 0; k < LINE_BYTES; k++) line[8*k +: 8] = shadow[addr[11:0] + k];
    return line;
  endfunction

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    assert (actual === expected) else begin
      value_errors++;
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic confirm(input logic cond, input string what);
    assert (cond) else begin
      other_errors++;
      $display("%0t: %s", $time, what);
    end
  endtask

  // one strobe, then wait for cpu_done sampled mid-cycle.
  task automatic issue_request(input cpu_req_t req, output logic [31:0] data);
    @(posedge clock);
    #1;
    cpu_req_valid = 1'b1;
    cpu_req = req;
    @(posedge clock);
    #1;
    cpu_req_valid = 1'b0;
    done_cycles = 0;
    do begin
      @(negedge clock);
      done_cycles++;
    end while (!cpu_done && done_cycles < REQUEST_TIMEOUT);
    data = cpu_rd_data;
    confirm(cpu_done, $sformatf("no cpu_done within %0d cycles for address %h",
                                REQUEST_TIMEOUT, req.addr));
  endtask

  task automatic load(input logic [31:0] addr, input size_t size, input logic is_signed);
    cpu_req_t    req;
    logic [31:0] data;
    logic [31:0] expected;
    req = '0;
    req.size = size;
    req.rd_signed = is_signed;
    req.addr = addr;
    expected = expected_load(addr, size, is_signed);
    issue_request(req, data);
    check_value("cpu_rd_data", data, expected);
  endtask

  task automatic store(input logic [31:0] addr, input size_t size, input logic [31:0] data);
    cpu_req_t    req;
    logic [31:0] rd_data_ignored;
    req = '0;
    req.write = 1'b1;
    req.size = size;
    req.addr = addr;
    req.wr_data = data;
    issue_request(req, rd_data_ignored);
    for (int i = 0; i < (1 << size); i++) shadow[addr[11:0] + i] = data[8*i +: 8];
  endtask

  task automatic cold_load_test();
    strobes.delete();
    load(32'h104, size_word, 1'b0);
    confirm(strobes.size() == 1 && !strobes[0].write,
            "cold load did not issue exactly one memory read");
    if (strobes.size() == 1) check_value("mem_req.addr", strobes[0].addr, 32'h100);
  endtask

  // upper store bits carry junk that must not land in memory.
  task automatic offset_test();
    store(32'h200, size_byte, 32'hdead_be85);
    store(32'h201, size_byte, 32'h1234_563c);
    store(32'h202, size_byte, 32'hffff_ffe1);
    store(32'h203, size_byte, 32'h0000_0047);
    store(32'h204, size_half, 32'hcafe_9abc);
    store(32'h206, size_half, 32'h0bad_1234);
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 3; s++) begin
        for (int off = 0; off < 4; off += (1 << s)) begin
          load(32'h200 + 4*w + off, size_t'(s), 1'b0);
          load(32'h200 + 4*w + off, size_t'(s), 1'b1);
        end
      end
    end
  endtask

  task automatic hit_timing_test();
    strobes.delete();
    load(32'h20c, size_word, 1'b0);
    confirm(done_cycles == 1, "hit load did not finish one cycle after the request");
    confirm(strobes.size() == 0, "hit load issued a memory request");
  endtask

  task automatic write_back_test();
    logic [BLOCK_SIZE-1:0] victim;
    store(32'h348, size_word, 32'h5a5a_c3c3);
    victim = shadow_line(32'h340);
    strobes.delete();
    load(32'h448, size_word, 1'b0);  // same index, new tag.
    confirm(strobes.size() == 2, "conflicting load did not issue a write-back and a refill");
    if (strobes.size() == 2) begin
      confirm(strobes[0].write && !strobes[1].write,
              "write-back and refill came in the wrong order");
      check_value("mem_req.addr", strobes[0].addr, 32'h340);
      check_value("mem_req.wr_data", strobes[0].wr_data, victim);
      check_value("mem_req.addr", strobes[1].addr, 32'h440);
    end
  endtask

  task automatic random_test();
    logic [31:0] addr;
    logic [31:0] data;
    size_t       size;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      size = size_t'($urandom_range(0, 2));
      addr = $urandom_range(0, 64 * LINE_BYTES - 1) & ~((32'd1 << size) - 1);
      data = $urandom;
      if ($urandom_range(0, 1)) store(addr, size, data);
      else load(addr, size, data[0]);
    end
    // a tag never used before evicts every line.
    for (int idx = 0; idx < CACHE_LINES; idx++) load(32'h800 + idx * LINE_BYTES, size_word, 1'b0);
    for (int a = 0; a < MEM_BYTES; a++) begin
      assert (mem_bytes[a] === shadow[a]) else begin
        value_errors++;
        $display("[FAIL] %0t: mem_bytes[%0h] is %h, expected %h", $time, a, mem_bytes[a],
                 shadow[a]);
      end
    end
  endtask

  // answers each strobe 2 to 5 cycles later; a read may follow in the ack cycle.
  initial begin : memory_model
    mem_req_t req;
    int       delay;
    mem_ack = 1'b0;
    mem_rd_data = '0;
    forever begin
      @(negedge clock);
      while (mem_req_valid) begin
        req = mem_req;
        strobes.push_back(req);
        confirm(req.addr[3:0] == 0 && req.addr < MEM_BYTES,
                "memory request address is not a line inside the modelled memory");
        if (req.write) begin
          for (int k = 0; k < LINE_BYTES; k++) begin
            mem_bytes[req.addr[11:0] + k] = req.wr_data[8*k +: 8];
          end
        end
        delay = $urandom_range(2, 5);
        repeat (delay) begin
          @(posedge clock);
          #1;
          mem_ack = 1'b0;
        end
        for (int k = 0; k < LINE_BYTES; k++) mem_rd_data[8*k +: 8] = mem_bytes[req.addr[11:0] + k];
        mem_ack = 1'b1;
        @(negedge clock);
      end
      if (mem_ack) begin
        @(posedge clock);
        #1;
        mem_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(CLOCK_PERIOD * (RESET_CYCLES + REQUEST_COUNT * REQUEST_TIMEOUT));
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(9));
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req = '0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_bytes[a] = fill_byte(a);
      shadow[a] = fill_byte(a);
    end
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    confirm(!cpu_done && !mem_req_valid, "cpu_done or mem_req_valid high after reset");
    cold_load_test();
    offset_test();
    hit_timing_test();
    write_back_test();
    random_test();
    $display("error counts: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/cache_pkg.sv
source/left_barrel_shifter.sv
source/right_barrel_shifter.sv
cache/cache_path.sv
cache/cache_control.sv
source/cache_subsystem.sv
test/cache_tb.sv
